//--- rtl/split_mem_pkg.sv
package split_mem_pkg;

    // Bus and lane geometry
    localparam int word_w     = 32;
    localparam int lane_count = 4;
    localparam int offset_w   = 2;

    // Bank depths in words
    localparam int imem_words = 2048;
    localparam int dmem_words = 1024;

    typedef logic [word_w-1:0] word_t;

    typedef logic [7:0] byte_t;

    // One write enable per lane
    typedef logic [lane_count-1:0] lane_mask_t;

    // Low address bits, selects the first lane of an access
    typedef logic [offset_w-1:0] byte_offset_t;

    // Encoding follows the core's store control field
    typedef enum logic [2:0] {
        store_none = 3'd0,
        store_byte = 3'd1,
        store_half = 3'd2,
        store_word = 3'd4
    } store_op_t;

endpackage

//--- rtl/byte_bank.sv
module byte_bank #(
    parameter int depth  = 1024,
    parameter int addr_w = $clog2(depth)
) (
    input  logic                 clk_1,
    input  logic                 en,
    input  logic                 we,
    input  logic [addr_w-1:0]    addr,
    input  split_mem_pkg::byte_t wdata,
    output split_mem_pkg::byte_t rdata
);

    import split_mem_pkg::*;

    byte_t mem [depth];

    // Read-first, a write cycle returns the old byte
    always_ff @(posedge clk_1) begin
        if (en) begin
            rdata <= mem[addr];
            if (we) begin
                mem[addr] <= wdata;
            end
        end
    end

    addr_in_range: assert property (
        @(posedge clk_1) en |-> (int'(addr) < depth)
    ) else $error("byte_bank: address %0d beyond depth %0d", addr, depth);

endmodule

//--- rtl/lane_router.sv
module lane_router #(
    parameter int addr_w = 10
) (
    input  logic                      clk_1,
    input  logic                      en,
    input  split_mem_pkg::word_t      addr,
    input  split_mem_pkg::word_t      din,
    input  split_mem_pkg::store_op_t  store_op,
    output logic [addr_w-1:0]         lane_addr [split_mem_pkg::lane_count],
    output split_mem_pkg::byte_t      lane_din [split_mem_pkg::lane_count],
    output split_mem_pkg::lane_mask_t lane_we
);

    import split_mem_pkg::*;

    byte_offset_t            offset;
    logic [addr_w-1:0]       word_idx;
    logic [addr_w-1:0]       next_idx;
    lane_mask_t              base_mask;
    logic [2*lane_count-1:0] mask_pair;

    assign offset   = addr[offset_w-1:0];
    assign word_idx = addr[addr_w+offset_w-1:offset_w];

    // Wraps at the bank depth by truncation
    assign next_idx = word_idx + 1'b1;

    // Lanes below the offset belong to the following word
    always_comb begin
        for (int k = 0; k < lane_count; k++) begin
            if (byte_offset_t'(k) < offset) begin
                lane_addr[k] = next_idx;
            end else begin
                lane_addr[k] = word_idx;
            end
        end
    end

    // Byte 0 of din goes to the lane at the offset
    always_comb begin
        byte_offset_t src;
        for (int k = 0; k < lane_count; k++) begin
            src         = byte_offset_t'(k) - offset;
            lane_din[k] = din[{src, 3'b000} +: 8];
        end
    end

    // Mask as if aligned, then rotated up by the offset
    always_comb begin
        unique case (store_op)
            store_byte: base_mask = 4'b0001;
            store_half: base_mask = 4'b0011;
            store_word: base_mask = 4'b1111;
            default:    base_mask = 4'b0000;
        endcase
    end

    // Upper half of the doubled mask is the rotation, so a halfword at 3 gives 1001
    assign mask_pair = {base_mask, base_mask} << offset;
    assign lane_we   = mask_pair[2*lane_count-1:lane_count];

    store_op_legal: assert property (
        @(posedge clk_1) en |-> store_op inside {store_none, store_byte, store_half, store_word}
    ) else $error("lane_router: illegal store_op %0d", store_op);

endmodule

//--- rtl/load_align.sv
module load_align (
    input  logic                        clk_1,
    input  logic                        rst_n_sync,
    input  logic                        en,
    input  split_mem_pkg::byte_offset_t offset,
    input  split_mem_pkg::byte_t        lane_dout [split_mem_pkg::lane_count],
    output split_mem_pkg::word_t        dout
);

    import split_mem_pkg::*;

    byte_offset_t offset_q;

    // Offset of the request whose data the banks now hold
    always_ff @(posedge clk_1 or negedge rst_n_sync) begin
        if (!rst_n_sync) begin
            offset_q <= '0;
        end else if (en) begin
            offset_q <= offset;
        end
    end

    // Byte j of the word comes from lane j + offset
    always_comb begin
        byte_offset_t lane;
        for (int j = 0; j < lane_count; j++) begin
            lane            = byte_offset_t'(j) + offset_q;
            dout[8*j +: 8]  = lane_dout[lane];
        end
    end

    offset_known: assert property (
        @(posedge clk_1) disable iff (!rst_n_sync)
        en |-> !$isunknown(offset)
    ) else $error("load_align: offset unknown on an accepted request");

endmodule

//--- rtl/mem_port.sv
module mem_port #(
    parameter int words = split_mem_pkg::dmem_words
) (
    input  logic                     clk_1,
    input  logic                     rst_n_sync,
    input  logic                     en,
    input  split_mem_pkg::store_op_t store_op,
    input  split_mem_pkg::word_t     addr,
    input  split_mem_pkg::word_t     din,
    output split_mem_pkg::word_t     dout
);

    import split_mem_pkg::*;

    localparam int addr_w = $clog2(words);

    logic [addr_w-1:0] lane_addr [lane_count];
    byte_t             lane_din [lane_count];
    byte_t             lane_dout [lane_count];
    lane_mask_t        lane_we;

    lane_router #(
        .addr_w(addr_w)
    ) lane_router_i (
        .clk_1     (clk_1),
        .en        (en),
        .addr      (addr),
        .din       (din),
        .store_op  (store_op),
        .lane_addr (lane_addr),
        .lane_din  (lane_din),
        .lane_we   (lane_we)
    );

    // One byte bank per lane, all enabled together
    for (genvar k = 0; k < lane_count; k++) begin : lane_g
        byte_bank #(
            .depth  (words),
            .addr_w (addr_w)
        ) bank_i (
            .clk_1 (clk_1),
            .en    (en),
            .we    (lane_we[k]),
            .addr  (lane_addr[k]),
            .wdata (lane_din[k]),
            .rdata (lane_dout[k])
        );
    end

    load_align load_align_i (
        .clk_1      (clk_1),
        .rst_n_sync (rst_n_sync),
        .en         (en),
        .offset     (addr[offset_w-1:0]),
        .lane_dout  (lane_dout),
        .dout       (dout)
    );

endmodule

//--- rtl/split_mem_top.sv
module split_mem_top (
    input  logic                     clk_1,
    input  logic                     rst_n_sync,

    // Instruction port
    input  logic                     imem_en,
    input  split_mem_pkg::store_op_t imem_store_op,
    input  split_mem_pkg::word_t     imem_addr,
    input  split_mem_pkg::word_t     imem_din,
    output split_mem_pkg::word_t     imem_dout,

    // Data port
    input  logic                     dmem_en,
    input  split_mem_pkg::store_op_t dmem_store_op,
    input  split_mem_pkg::word_t     dmem_addr,
    input  split_mem_pkg::word_t     dmem_din,
    output split_mem_pkg::word_t     dmem_dout
);

    import split_mem_pkg::*;

    mem_port #(
        .words(imem_words)
    ) imem_port_i (
        .clk_1      (clk_1),
        .rst_n_sync (rst_n_sync),
        .en         (imem_en),
        .store_op   (imem_store_op),
        .addr       (imem_addr),
        .din        (imem_din),
        .dout       (imem_dout)
    );

    // Separate memory, no address sharing with the instruction side
    mem_port #(
        .words(dmem_words)
    ) dmem_port_i (
        .clk_1      (clk_1),
        .rst_n_sync (rst_n_sync),
        .en         (dmem_en),
        .store_op   (dmem_store_op),
        .addr       (dmem_addr),
        .din        (dmem_din),
        .dout       (dmem_dout)
    );

endmodule

//--- testbench/tb_split_mem.sv
module tb_split_mem;

    timeunit 1ns;
    timeprecision 1ps;

    import split_mem_pkg::*;

    localparam int clk_period   = 10;
    localparam int reset_cycles = 4;
    localparam int random_ops   = 300;

    localparam bit imem_p = 1'b0;
    localparam bit dmem_p = 1'b1;

    localparam int imem_bytes = imem_words * lane_count;
    localparam int dmem_bytes = dmem_words * lane_count;

    // One row of the directed table
    typedef struct {
        bit        port;
        bit        en;
        store_op_t op;
        word_t     addr;
        word_t     din;
        bit        check;
        word_t     exp;
    } step_t;

    logic      clk_1;
    logic      rst_n_sync;

    logic      imem_en;
    store_op_t imem_store_op;
    word_t     imem_addr;
    word_t     imem_din;
    word_t     imem_dout;

    logic      dmem_en;
    store_op_t dmem_store_op;
    word_t     dmem_addr;
    word_t     dmem_din;
    word_t     dmem_dout;

    step_t     steps [$];
    int        table_len;

    // Byte-level reference memories, one per port
    byte_t     model_mem [2][imem_bytes];
    bit        model_known [2][imem_bytes];

    // Expected dout per port and which of its bytes are known
    word_t     last_exp [2];
    word_t     last_mask [2];

    split_mem_top dut_i (
        .clk_1         (clk_1),
        .rst_n_sync    (rst_n_sync),
        .imem_en       (imem_en),
        .imem_store_op (imem_store_op),
        .imem_addr     (imem_addr),
        .imem_din      (imem_din),
        .imem_dout     (imem_dout),
        .dmem_en       (dmem_en),
        .dmem_store_op (dmem_store_op),
        .dmem_addr     (dmem_addr),
        .dmem_din      (dmem_din),
        .dmem_dout     (dmem_dout)
    );

    initial begin
        clk_1 = 1'b0;
        forever #(clk_period / 2) clk_1 = ~clk_1;
    end

    function automatic int port_bytes(input bit p);
        return (p == imem_p) ? imem_bytes : dmem_bytes;
    endfunction

    function automatic string port_name(input bit p);
        return (p == imem_p) ? "imem_dout" : "dmem_dout";
    endfunction

    // Byte address wraps at the size of the port's memory
    function automatic int byte_index(input word_t addr, input int offs, input int size);
        return int'((addr + word_t'(offs)) % word_t'(size));
    endfunction

    function automatic word_t window_base(input bit p);
        return (p == imem_p) ? 32'h0000_1fe0 : 32'h0000_0fe0;
    endfunction

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("** Error at %0t: %s expected 0x%08h, got 0x%08h",
                     $time, name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "data mismatch on %s", name);
        end
    endtask

    // Drives one port and updates the reference model
    task automatic apply_request(input bit p, input bit en, input store_op_t op,
                                 input word_t addr, input word_t din);
        int nbytes;
        int size;
        int a;
        if (p == imem_p) begin
            imem_en       = en;
            imem_store_op = op;
            imem_addr     = addr;
            imem_din      = din;
        end else begin
            dmem_en       = en;
            dmem_store_op = op;
            dmem_addr     = addr;
            dmem_din      = din;
        end
        if (en) begin
            size = port_bytes(p);
            // Read-first, so the old bytes are captured before the store
            for (int j = 0; j < lane_count; j++) begin
                a = byte_index(addr, j, size);
                last_exp[p][8*j +: 8]  = model_mem[p][a];
                last_mask[p][8*j +: 8] = model_known[p][a] ? 8'hff : 8'h00;
            end
            case (op)
                store_byte: nbytes = 1;
                store_half: nbytes = 2;
                store_word: nbytes = 4;
                default:    nbytes = 0;
            endcase
            for (int i = 0; i < nbytes; i++) begin
                a = byte_index(addr, i, size);
                model_mem[p][a]   = din[8*i +: 8];
                model_known[p][a] = 1'b1;
            end
        end
    endtask

    task automatic add_step(input bit port, input bit en, input store_op_t op,
                            input word_t addr, input word_t din,
                            input bit check, input word_t exp);
        step_t s;
        s.port  = port;
        s.en    = en;
        s.op    = op;
        s.addr  = addr;
        s.din   = din;
        s.check = check;
        s.exp   = exp;
        steps.push_back(s);
    endtask

    task automatic build_table();
        // Same address on both ports, different data
        add_step(imem_p, 1, store_word, 32'h0000_0100, 32'h1122_3344, 0, 32'h0);
        add_step(dmem_p, 1, store_word, 32'h0000_0100, 32'ha5a5_5a5a, 0, 32'h0);
        add_step(imem_p, 1, store_none, 32'h0000_0100, 32'h0, 1, 32'h1122_3344);
        add_step(dmem_p, 1, store_none, 32'h0000_0100, 32'h0, 1, 32'ha5a5_5a5a);

        // Byte then halfword into one word
        add_step(dmem_p, 1, store_word, 32'h0000_0200, 32'h1122_3344, 0, 32'h0);
        add_step(dmem_p, 1, store_byte, 32'h0000_0202, 32'h0000_00ab, 0, 32'h0);
        add_step(dmem_p, 1, store_none, 32'h0000_0200, 32'h0, 1, 32'h11ab_3344);
        add_step(dmem_p, 1, store_half, 32'h0000_0201, 32'h0000_beef, 0, 32'h0);
        add_step(dmem_p, 1, store_none, 32'h0000_0200, 32'h0, 1, 32'h11be_ef44);
        // Upper address bits alias back onto the same word
        add_step(dmem_p, 1, store_none, 32'h0000_1200, 32'h0, 1, 32'h11be_ef44);

        // Word at offset 3 straddles two words
        add_step(dmem_p, 1, store_word, 32'h0000_0300, 32'h0, 0, 32'h0);
        add_step(dmem_p, 1, store_word, 32'h0000_0304, 32'h0, 0, 32'h0);
        add_step(dmem_p, 1, store_word, 32'h0000_0303, 32'hddcc_bbaa, 1, 32'h0);
        add_step(dmem_p, 1, store_none, 32'h0000_0300, 32'h0, 1, 32'haa00_0000);
        add_step(dmem_p, 1, store_none, 32'h0000_0304, 32'h0, 1, 32'h00dd_ccbb);
        add_step(dmem_p, 1, store_none, 32'h0000_0303, 32'h0, 1, 32'hddcc_bbaa);

        // Halfword at offset 3 hits lane 3 and lane 0 of the next word
        add_step(imem_p, 1, store_word, 32'h0000_0400, 32'h4433_2211, 0, 32'h0);
        add_step(imem_p, 1, store_word, 32'h0000_0404, 32'h8877_6655, 0, 32'h0);
        add_step(imem_p, 1, store_half, 32'h0000_0403, 32'h0000_cdef, 0, 32'h0);
        add_step(imem_p, 1, store_none, 32'h0000_0400, 32'h0, 1, 32'hef33_2211);
        add_step(imem_p, 1, store_none, 32'h0000_0404, 32'h0, 1, 32'h8877_66cd);

        // Last word of dmem wraps to word 0
        add_step(dmem_p, 1, store_word, 32'h0000_0ffc, 32'h0, 0, 32'h0);
        add_step(dmem_p, 1, store_word, 32'h0000_0000, 32'h0, 0, 32'h0);
        add_step(dmem_p, 1, store_word, 32'h0000_0ffe, 32'h4433_2211, 1, 32'h0);
        add_step(dmem_p, 1, store_none, 32'h0000_0ffc, 32'h0, 1, 32'h2211_0000);
        add_step(dmem_p, 1, store_none, 32'h0000_0000, 32'h0, 1, 32'h0000_4433);

        // Read-first on a write, then dout holds while idle
        add_step(imem_p, 1, store_word, 32'h0000_0100, 32'hcafe_f00d, 1, 32'h1122_3344);
        add_step(imem_p, 0, store_none, 32'h0000_0500, 32'h0, 1, 32'h1122_3344);
        add_step(imem_p, 0, store_word, 32'h0000_0100, 32'hffff_ffff, 1, 32'h1122_3344);
        add_step(dmem_p, 1, store_none, 32'h0000_0100, 32'h0, 1, 32'ha5a5_5a5a);
        add_step(imem_p, 1, store_none, 32'h0000_0100, 32'h0, 1, 32'hcafe_f00d);

        table_len = steps.size();
    endtask

    task automatic drive_step(input int i);
        step_t s;
        s = steps[i];
        apply_request(s.port, s.en, s.op, s.addr, s.din);
        apply_request(~s.port, 1'b0, store_none, 32'h0, 32'h0);
    endtask

    task automatic check_step(input int i);
        step_t s;
        s = steps[i];
        if (s.check) begin
            if (s.port == imem_p) begin
                check_word("imem_dout", s.exp, imem_dout);
            end else begin
                check_word("dmem_dout", s.exp, dmem_dout);
            end
        end
    endtask

    task automatic drive_random(input bit p);
        bit        en;
        store_op_t op;
        word_t     addr;
        word_t     din;
        en = ($urandom % 8) != 0;
        case ($urandom % 4)
            0:       op = store_none;
            1:       op = store_byte;
            2:       op = store_half;
            default: op = store_word;
        endcase
        addr = window_base(p) + ($urandom % 64) + (($urandom % 2) << 20);
        din  = $urandom;
        apply_request(p, en, op, addr, din);
    endtask

    // Only bytes the model has seen written are compared
    task automatic check_port(input bit p);
        word_t actual;
        actual = (p == imem_p) ? imem_dout : dmem_dout;
        if (last_mask[p] != '0) begin
            check_word(port_name(p), last_exp[p] & last_mask[p], actual & last_mask[p]);
        end
    endtask

    initial begin
        wait (table_len > 0);
        #((table_len + random_ops + reset_cycles + 20) * clk_period);
        $display("Watchdog expired at %0t, the test sequence did not finish in time", $time);
        $display("Simulation failed");
        $fatal(1, "watchdog timeout");
    end

    initial begin
        void'($urandom(32'h76e6));
        rst_n_sync    = 1'b0;
        imem_en       = 1'b0;
        imem_store_op = store_none;
        imem_addr     = '0;
        imem_din      = '0;
        dmem_en       = 1'b0;
        dmem_store_op = store_none;
        dmem_addr     = '0;
        dmem_din      = '0;
        last_exp      = '{default: '0};
        last_mask     = '{default: '0};

        build_table();

        repeat (reset_cycles) @(posedge clk_1);
        @(negedge clk_1);
        rst_n_sync = 1'b1;
        @(negedge clk_1);

        for (int i = 0; i < table_len; i++) begin
            drive_step(i);
            @(negedge clk_1);
            check_step(i);
        end

        // Both ports busy at once in the random phase
        for (int n = 0; n < random_ops; n++) begin
            drive_random(imem_p);
            drive_random(dmem_p);
            @(negedge clk_1);
            check_port(imem_p);
            check_port(dmem_p);
        end

        imem_en = 1'b0;
        dmem_en = 1'b0;

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- files.f
rtl/split_mem_pkg.sv
rtl/byte_bank.sv
rtl/lane_router.sv
rtl/load_align.sv
rtl/mem_port.sv
rtl/split_mem_top.sv
testbench/tb_split_mem.sv

//--- Makefile
# Verilator build and run for the split memory testbench

VERILATOR ?= verilator
TOP       ?= tb_split_mem
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= files.f
VFLAGS    ?= --binary --timing --assert

SRCS    := $(wildcard rtl/*.sv) $(wildcard testbench/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log search decides pass or fail
run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
